/* Makefile */
VERILATOR ?= verilator
TOP       ?= gfx_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run counts as passed only when the pass line shows up in its output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* logic/cpu_port.sv */
`timescale 1ns/1ps

module cpu_port
    import gfx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axil_req_t  axil_req,
    output axil_rsp_t  axil_rsp,
    input  logic       lvbl,
    input  logic       pxl_cen,
    input  logic [7:0] map_addr,
    output map_entry_t map_entry,
    output gfx_cfg_t   cfg,
    output logic       irq_n
);

    map_entry_t  map_ram [map_dim*map_dim];
    logic [6:0]  scroll_x_q;
    logic [6:0]  scroll_y_q;
    logic [31:0] ctrl_q;
    logic        lvbl_l;
    logic        wr_go;
    logic        wr_hit;
    logic [31:0] wr_word;
    logic        rd_go;
    logic        rd_hit;
    logic [31:0] rd_word;
    logic        irq_ack;

    function automatic logic [31:0] strb_merge(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = strb[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic addr_ok(input logic [11:0] addr);
        return addr < reg_base || addr == reg_scroll_x || addr == reg_scroll_y ||
               addr == reg_ctrl || addr == reg_irq;
    endfunction

    // Current contents at an address or zero when unmapped
    function automatic logic [31:0] read_word(input logic [11:0] addr);
        logic [31:0] word;
        word = '0;
        if (addr < reg_base) begin
            word = {21'd0, map_ram[addr[9:2]]};
        end else begin
            case (addr)
                reg_scroll_x: word = {25'd0, scroll_x_q};
                reg_scroll_y: word = {25'd0, scroll_y_q};
                reg_ctrl:     word = ctrl_q;
                reg_irq:      word = {31'd0, ~irq_n};
                default:      word = '0;
            endcase
        end
        return word;
    endfunction

    // Handshake cycles are the ones where the ready strobes are up
    assign wr_go = axil_rsp.awready;
    assign rd_go = axil_rsp.arready;

    always_comb begin
        wr_hit  = addr_ok(axil_req.awaddr);
        wr_word = strb_merge(read_word(axil_req.awaddr), axil_req.wdata, axil_req.wstrb);
        rd_hit  = addr_ok(axil_req.araddr);
        rd_word = read_word(axil_req.araddr);
    end

    assign irq_ack = wr_go && axil_req.awaddr == reg_irq && wr_word[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            axil_rsp <= '0;
        end else begin
            axil_rsp.awready <= 1'b0;
            axil_rsp.wready  <= 1'b0;
            axil_rsp.arready <= 1'b0;
            if (axil_req.awvalid && axil_req.wvalid && !wr_go && !axil_rsp.bvalid) begin
                axil_rsp.awready <= 1'b1;
                axil_rsp.wready  <= 1'b1;
            end
            if (wr_go) begin
                axil_rsp.bvalid <= 1'b1;
                axil_rsp.bresp  <= wr_hit ? resp_okay : resp_slverr;
            end else if (axil_rsp.bvalid && axil_req.bready) begin
                axil_rsp.bvalid <= 1'b0;
            end
            // One read in flight at a time
            if (axil_req.arvalid && !rd_go && !axil_rsp.rvalid) begin
                axil_rsp.arready <= 1'b1;
            end
            if (rd_go) begin
                axil_rsp.rvalid <= 1'b1;
                axil_rsp.rdata  <= rd_word;
                axil_rsp.rresp  <= rd_hit ? resp_okay : resp_slverr;
            end else if (axil_rsp.rvalid && axil_req.rready) begin
                axil_rsp.rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scroll_x_q <= '0;
            scroll_y_q <= '0;
            ctrl_q     <= '0;
        end else if (wr_go) begin
            case (axil_req.awaddr)
                reg_scroll_x: scroll_x_q <= wr_word[6:0];
                reg_scroll_y: scroll_y_q <= wr_word[6:0];
                reg_ctrl:     ctrl_q     <= wr_word & ctrl_mask;
                default: begin
                end
            endcase
        end
    end

    // Tile map with a CPU write port and a fetch read port
    always_ff @(posedge clk) begin
        if (wr_go && axil_req.awaddr < reg_base) begin
            map_ram[axil_req.awaddr[9:2]] <= wr_word[10:0];
        end
        map_entry <= map_ram[map_addr];
    end

    // Vblank interrupt set on the falling edge of lvbl
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            if (irq_ack) begin
                irq_n <= 1'b1;
            end
            if (pxl_cen) begin
                lvbl_l <= lvbl;
                if (lvbl_l && !lvbl && ctrl_q[ctrl_irq_en]) begin
                    irq_n <= 1'b0;
                end
            end
        end
    end

    assign cfg = '{
        scroll_x:  scroll_x_q,
        scroll_y:  scroll_y_q,
        enable:    ctrl_q[ctrl_enable],
        pal_bank:  ctrl_q[ctrl_pal_lo +: 2],
        bg_colour: ctrl_q[ctrl_bg_lo +: 4]
    };

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

/* logic/gfx_pkg.sv */
package gfx_pkg;

    // Screen and map geometry
    localparam int line_w    = 64;
    localparam int map_dim   = 16;
    localparam int tile_w    = 8;
    localparam int h_total   = 96;
    localparam int v_visible = 64;
    localparam int v_total   = 72;

    // Graphics ROM word address is code x 8 + tile row
    localparam int rom_aw = 11;

    // Register map with the tile map below reg_base
    localparam logic [11:0] reg_base     = 12'h400;
    localparam logic [11:0] reg_scroll_x = 12'h400;
    localparam logic [11:0] reg_scroll_y = 12'h404;
    localparam logic [11:0] reg_ctrl     = 12'h408;
    localparam logic [11:0] reg_irq      = 12'h40C;

    // Bit positions inside reg_ctrl
    localparam int          ctrl_enable = 0;
    localparam int          ctrl_irq_en = 1;
    localparam int          ctrl_pal_lo = 4;
    localparam int          ctrl_bg_lo  = 8;
    localparam logic [31:0] ctrl_mask   = 32'h0000_0F33;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef struct packed {
        logic        awvalid;
        logic [11:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [11:0] araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    // Stored in wdata[10:0] of a map word
    typedef struct packed {
        logic [7:0] code;
        logic [1:0] pal;
        logic       hflip;
    } map_entry_t;

    typedef struct packed {
        logic [6:0] scroll_x;
        logic [6:0] scroll_y;
        logic       enable;
        logic [1:0] pal_bank;
        logic [3:0] bg_colour;
    } gfx_cfg_t;

    typedef struct packed {
        logic       pxl_cen;
        logic [6:0] hdump;
        logic [6:0] vdump;
        logic       lhbl;
        logic       lvbl;
    } video_t;

    typedef struct packed {
        logic [1:0] pal;
        logic [3:0] colour;
    } lbuf_pix_t;

    typedef struct packed {
        logic       we;
        logic       bank;
        logic [5:0] addr;
        lbuf_pix_t  pix;
    } lbuf_wr_t;

    typedef struct packed {
        logic [1:0] pal_bank;
        logic [1:0] pal;
        logic [3:0] colour;
    } pixel_t;

endpackage

/* logic/gfx_top.sv */
`timescale 1ns/1ps

module gfx_top
    import gfx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  axil_req_t         axil_req,
    output axil_rsp_t         axil_rsp,
    input  video_t            video,
    output logic              rom_cs,
    output logic [rom_aw-1:0] rom_addr,
    input  logic [31:0]       rom_data,
    input  logic              rom_ok,
    output pixel_t            pixel_out,
    output logic              irq_n
);

    gfx_cfg_t   cfg;
    logic [7:0] map_addr;
    map_entry_t map_entry;
    lbuf_wr_t   lbuf_wr;
    logic       rd_bank;
    logic [5:0] rd_addr;
    lbuf_pix_t  rd_pix;

    cpu_port i_cpu_port (
        .clk       (clk),
        .rst       (rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .lvbl      (video.lvbl),
        .pxl_cen   (video.pxl_cen),
        .map_addr  (map_addr),
        .map_entry (map_entry),
        .cfg       (cfg),
        .irq_n     (irq_n)
    );

    // Busy is only checked inside the fetch
    tile_fetch i_tile_fetch (
        .clk       (clk),
        .rst       (rst),
        .video     (video),
        .cfg       (cfg),
        .map_addr  (map_addr),
        .map_entry (map_entry),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .lbuf_wr   (lbuf_wr),
        .busy      ()
    );

    line_buffer i_line_buffer (
        .clk     (clk),
        .wr      (lbuf_wr),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_pix  (rd_pix)
    );

    pixel_mixer i_pixel_mixer (
        .clk       (clk),
        .rst       (rst),
        .video     (video),
        .cfg       (cfg),
        .rd_bank   (rd_bank),
        .rd_addr   (rd_addr),
        .rd_pix    (rd_pix),
        .pixel_out (pixel_out)
    );

endmodule

/* logic/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer
    import gfx_pkg::*;
(
    input  logic       clk,
    input  lbuf_wr_t   wr,
    input  logic       rd_bank,
    input  logic [5:0] rd_addr,
    output lbuf_pix_t  rd_pix
);

    // Both banks in one array with the bank bit on top of the address
    lbuf_pix_t  mem [2*line_w];
    logic [6:0] wr_idx;
    logic [6:0] rd_idx;

    assign wr_idx = {wr.bank, wr.addr};
    assign rd_idx = {rd_bank, rd_addr};

    // Render side
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr_idx] <= wr.pix;
        end
    end

    // Display side with one cycle read latency
    always_ff @(posedge clk) begin
        rd_pix <= mem[rd_idx];
    end

endmodule

/* logic/pixel_mixer.sv */
`timescale 1ns/1ps

module pixel_mixer
    import gfx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  video_t     video,
    input  gfx_cfg_t   cfg,
    output logic       rd_bank,
    output logic [5:0] rd_addr,
    input  lbuf_pix_t  rd_pix,
    output pixel_t     pixel_out
);

    logic   cap_valid;
    logic   transparent;
    pixel_t mixed;

    // Colour 0 lets the background through
    assign transparent = rd_pix.colour == 4'd0 || !cfg.enable;

    always_comb begin
        mixed.pal_bank = cfg.pal_bank;
        if (transparent) begin
            mixed.pal    = 2'd0;
            mixed.colour = cfg.bg_colour;
        end else begin
            mixed.pal    = rd_pix.pal;
            mixed.colour = rd_pix.colour;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cap_valid <= 1'b0;
            rd_bank   <= 1'b0;
            rd_addr   <= '0;
            pixel_out <= '0;
        end else if (video.pxl_cen) begin
            cap_valid <= video.lhbl && video.lvbl;
            if (video.lhbl && video.lvbl) begin
                rd_bank <= video.vdump[0];
                rd_addr <= video.hdump[5:0];
            end
            // Buffer data arrived one clk after the capture
            pixel_out <= cap_valid ? mixed : '0;
        end
    end

endmodule

/* logic/tile_fetch.sv */
`timescale 1ns/1ps

module tile_fetch
    import gfx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  video_t            video,
    input  gfx_cfg_t          cfg,
    output logic [7:0]        map_addr,
    input  map_entry_t        map_entry,
    output logic              rom_cs,
    output logic [rom_aw-1:0] rom_addr,
    input  logic [31:0]       rom_data,
    input  logic              rom_ok,
    output lbuf_wr_t          lbuf_wr,
    output logic              busy
);

    typedef enum logic [1:0] {f_idle, f_map, f_rom, f_next} fetch_st_t;

    fetch_st_t  fstate;
    logic [3:0] ftile;
    logic       lhbl_l;
    logic       start;
    logic [6:0] next_line;
    logic       bank_q;
    logic [6:0] sx_q;
    logic [6:0] y_q;
    logic [3:0] col;
    // One fetched word waiting for the draw stage
    logic        hold_valid;
    logic [31:0] hold_word;
    logic [1:0]  hold_pal;
    logic        hold_hflip;
    logic [3:0]  hold_tile;
    // Draw stage
    logic        load;
    logic        d_active;
    logic [2:0]  d_pix;
    logic [31:0] d_word;
    logic [1:0]  d_pal;
    logic        d_hflip;
    logic [3:0]  d_tile;
    logic [7:0]  pos;
    logic [2:0]  nib_sel;

    assign start     = video.pxl_cen && lhbl_l && !video.lhbl;
    assign next_line = (video.vdump == 7'(v_total - 1)) ? 7'd0 : video.vdump + 7'd1;

    assign col      = 4'(sx_q[6:3] + ftile);
    assign map_addr = {y_q[6:3], col};
    assign rom_cs   = fstate == f_rom;
    // Map entry is valid throughout f_rom as map_addr holds
    assign rom_addr = {map_entry.code, y_q[2:0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fstate     <= f_idle;
            ftile      <= '0;
            lhbl_l     <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            if (video.pxl_cen) begin
                lhbl_l <= video.lhbl;
            end
            if (load) begin
                hold_valid <= 1'b0;
            end
            case (fstate)
                f_idle: begin
                    if (start) begin
                        ftile  <= '0;
                        fstate <= f_map;
                    end
                end
                f_map: fstate <= f_rom;
                f_rom: begin
                    if (rom_ok) begin
                        hold_valid <= 1'b1;
                        fstate     <= f_next;
                    end
                end
                default: begin
                    // Wait until the draw stage has taken the word
                    if (!hold_valid) begin
                        if (ftile == 4'(line_w / tile_w)) begin
                            fstate <= f_idle;
                        end else begin
                            ftile  <= ftile + 4'd1;
                            fstate <= f_map;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fstate == f_idle && start) begin
            bank_q <= next_line[0];
            sx_q   <= cfg.scroll_x;
            y_q    <= next_line + cfg.scroll_y;
        end
        if (fstate == f_rom && rom_ok) begin
            hold_word  <= rom_data;
            hold_pal   <= map_entry.pal;
            hold_hflip <= map_entry.hflip;
            hold_tile  <= ftile;
        end
    end

    // Next tile may follow pixel 7 without a gap
    assign load = hold_valid && (!d_active || d_pix == 3'd7);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_active <= 1'b0;
            d_pix    <= '0;
        end else if (load) begin
            d_active <= 1'b1;
            d_pix    <= '0;
        end else if (d_active) begin
            d_pix <= d_pix + 3'd1;
            if (d_pix == 3'd7) begin
                d_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            d_word  <= hold_word;
            d_pal   <= hold_pal;
            d_hflip <= hold_hflip;
            d_tile  <= hold_tile;
        end
    end

    // Screen x of the pixel with tile 0 shifted left by the fine scroll
    assign pos     = {1'b0, d_tile, 3'b000} + {5'd0, d_pix} - {5'd0, sx_q[2:0]};
    assign nib_sel = d_hflip ? ~d_pix : d_pix;

    always_comb begin
        lbuf_wr.we         = d_active && pos < 8'(line_w);
        lbuf_wr.bank       = bank_q;
        lbuf_wr.addr       = pos[5:0];
        lbuf_wr.pix.pal    = d_pal;
        lbuf_wr.pix.colour = d_word[{nib_sel, 2'b00} +: 4];
    end

    assign busy = fstate != f_idle || hold_valid || d_active;

    a_rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr));
    a_line_done: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy);

endmodule

/* sources.f */
+incdir+verif
logic/gfx_pkg.sv
logic/cpu_port.sv
logic/tile_fetch.sv
logic/line_buffer.sv
logic/pixel_mixer.sv
logic/gfx_top.sv
verif/gfx_tb.sv

/* verif/gfx_model.svh */
// Shadow copy of what the CPU has written
map_entry_t shadow_map [map_dim*map_dim];
gfx_cfg_t   shadow_cfg;
logic       shadow_irq_en;
// Visible pixels are only compared while the shadow matches the DUT
logic       model_ok;

// Graphics ROM content as a mixing hash of the full word address
function automatic logic [31:0] rom_word(input logic [rom_aw-1:0] addr);
    logic [31:0] h;
    h = {21'd0, addr} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h85eb_ca77;
    h = h ^ (h >> 13);
    return h;
endfunction

// Control register layout of enable, irq_en, palette bank and background colour
function automatic logic [31:0] ctrl_word(input gfx_cfg_t cfg, input logic irq_en);
    return {20'd0, cfg.bg_colour, 2'd0, cfg.pal_bank, 2'd0, irq_en, cfg.enable};
endfunction

// Colour seen at one dump position
function automatic pixel_t expect_pixel(input video_t v);
    pixel_t      px;
    int          xx;
    int          yy;
    logic [3:0]  row;
    logic [3:0]  col;
    logic [2:0]  r;
    logic [2:0]  p;
    logic [2:0]  nib;
    map_entry_t  ent;
    logic [31:0] word;
    logic [3:0]  colour;
    px = '0;
    if (v.lhbl && v.lvbl) begin
        xx = int'(v.hdump) + int'(shadow_cfg.scroll_x);
        yy = int'(v.vdump) + int'(shadow_cfg.scroll_y);
        row = 4'(yy / tile_w);
        col = 4'(xx / tile_w);
        r = 3'(yy % tile_w);
        p = 3'(xx % tile_w);
        ent = shadow_map[{row, col}];
        word = rom_word(rom_aw'(int'(ent.code) * tile_w + int'(r)));
        nib = ent.hflip ? 3'd7 - p : p;
        colour = word[{nib, 2'b00} +: 4];
        px.pal_bank = shadow_cfg.pal_bank;
        if (!shadow_cfg.enable || colour == 4'd0) begin
            px.colour = shadow_cfg.bg_colour;
        end else begin
            px.pal    = ent.pal;
            px.colour = colour;
        end
    end
    return px;
endfunction

task automatic check_pixel(input pixel_t got, input pixel_t exp, input string name);
    if (got !== exp) begin
        report_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp) begin
        report_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    end
endtask

task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string name);
    if (got !== exp) begin
        report_error($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    end
endtask

task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
        report_error($sformatf("FAIL t=%0t irq_n got %b expected %b", $time, got, exp));
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        report_error($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    end
endtask

/* verif/gfx_tb.sv */
`timescale 1ns/1ps

module gfx_tb
    import gfx_pkg::*;
();

    localparam int n_frames = 4;
    localparam int axi_ops  = 2 * map_dim * map_dim + 16 * n_frames + 48;
    localparam int wd_clks  = (n_frames + 2) * v_total * h_total * 2 + axi_ops * 16;

    logic              clk;
    logic              rst;
    axil_req_t         axil_req;
    axil_rsp_t         axil_rsp;
    video_t            video;
    logic              rom_cs;
    logic [rom_aw-1:0] rom_addr;
    logic [31:0]       rom_data;
    logic              rom_ok;
    pixel_t            pixel_out;
    logic              irq_n;
    logic [2:0]        rom_lat [256];

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    `include "gfx_model.svh"

    gfx_top i_gfx_top (
        .clk       (clk),
        .rst       (rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .video     (video),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pixel_out (pixel_out),
        .irq_n     (irq_n)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Video timing with one pixel every second clk
    initial begin
        video = '0;
        video.lhbl = 1'b1;
        video.lvbl = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (video.pxl_cen) begin
                if (video.hdump == 7'(h_total - 1)) begin
                    video.hdump = 7'd0;
                    video.vdump = (video.vdump == 7'(v_total - 1)) ? 7'd0 : video.vdump + 7'd1;
                end else begin
                    video.hdump = video.hdump + 7'd1;
                end
            end
            video.pxl_cen = !video.pxl_cen;
            video.lhbl = video.hdump < 7'(line_w);
            video.lvbl = video.vdump < 7'(v_visible);
        end
    end

    // Graphics ROM with latencies from a table filled after seeding
    initial begin
        logic [7:0] lat_idx;
        rom_ok = 1'b0;
        rom_data = '0;
        lat_idx = '0;
        forever begin
            @(negedge clk);
            if (rom_cs) begin
                repeat (rom_lat[lat_idx]) @(posedge clk);
                lat_idx = lat_idx + 8'd1;
                #1;
                rom_ok = 1'b1;
                rom_data = rom_word(rom_addr);
                @(posedge clk);
                #1;
                rom_ok = 1'b0;
            end
        end
    end

    // Pixel checker where the output follows the dump by one pixel
    initial begin
        video_t cur_v;
        video_t prev_v;
        logic   cur_ok;
        logic   prev_ok;
        cur_ok = 1'b0;
        cur_v = '0;
        @(negedge rst);
        forever begin
            @(posedge clk);
            if (video.pxl_cen) begin
                prev_v = cur_v;
                prev_ok = cur_ok;
                cur_v = video;
                cur_ok = 1'b1;
                @(negedge clk);
                if (prev_ok && (!(prev_v.lhbl && prev_v.lvbl) || model_ok)) begin
                    check_pixel(pixel_out, expect_pixel(prev_v), "pixel_out");
                end
            end
        end
    end

    initial begin
        repeat (wd_clks) @(posedge clk);
        report_error("Watchdog expired before the test sequence finished");
    end

    task automatic bus_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        #1;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr = addr;
        axil_req.wvalid = 1'b1;
        axil_req.wdata = data;
        axil_req.wstrb = 4'hf;
        axil_req.bready = 1'b1;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        @(posedge clk);
        #1;
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        resp = axil_rsp.bresp;
        @(posedge clk);
        #1;
        axil_req.bready = 1'b0;
    endtask

    task automatic bus_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        #1;
        axil_req.arvalid = 1'b1;
        axil_req.araddr = addr;
        axil_req.rready = 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(posedge clk);
        #1;
        axil_req.arvalid = 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        #1;
        axil_req.rready = 1'b0;
    endtask

    task automatic write_checked(input logic [11:0] addr, input logic [31:0] data,
                                 input logic [1:0] exp_resp);
        logic [1:0] resp;
        bus_write(addr, data, resp);
        check_resp(resp, exp_resp, $sformatf("bresp@%h", addr));
    endtask

    task automatic read_checked(input logic [11:0] addr, input logic [31:0] exp_data,
                                input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        bus_read(addr, data, resp);
        check_resp(resp, exp_resp, $sformatf("rresp@%h", addr));
        check_rdata(data, exp_data, $sformatf("rdata@%h", addr));
    endtask

    task automatic read_back_regs();
        read_checked(reg_scroll_x, {25'd0, shadow_cfg.scroll_x}, resp_okay);
        read_checked(reg_scroll_y, {25'd0, shadow_cfg.scroll_y}, resp_okay);
        read_checked(reg_ctrl, ctrl_word(shadow_cfg, shadow_irq_en), resp_okay);
    endtask

    // Returns on the clk after the pixel edge that starts vblank
    task automatic wait_vblank();
        @(posedge clk);
        while (!(video.pxl_cen && video.vdump == 7'(v_visible) && video.hdump == 7'd0)) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        map_entry_t  ent;
        logic [7:0]  idx;
        logic [11:0] bad_addr;
        void'($urandom(32'h3dd5e75c));
        for (int i = 0; i < 256; i++) begin
            rom_lat[8'(i)] = 3'($urandom_range(6, 1));
        end
        rst = 1'b1;
        axil_req = '0;
        shadow_cfg = '0;
        shadow_irq_en = 1'b0;
        model_ok = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        check_irq(irq_n, 1'b1);
        check_flag(rom_cs, 1'b0, "rom_cs");
        check_flag(axil_rsp.bvalid, 1'b0, "bvalid");
        check_flag(axil_rsp.rvalid, 1'b0, "rvalid");
        check_pixel(pixel_out, '0, "pixel_out");

        // Random tile map written and then read back
        for (int i = 0; i < map_dim * map_dim; i++) begin
            ent = 11'($urandom);
            shadow_map[8'(i)] = ent;
            write_checked(12'(i * 4), {21'd0, ent}, resp_okay);
        end
        for (int i = 0; i < map_dim * map_dim; i++) begin
            read_checked(12'(i * 4), {21'd0, shadow_map[8'(i)]}, resp_okay);
        end

        for (int f = 0; f < n_frames; f++) begin
            wait_vblank();
            check_irq(irq_n, !shadow_irq_en);
            write_checked(reg_irq, 32'd1, resp_okay);
            check_irq(irq_n, 1'b1);
            model_ok = 1'b0;
            read_checked(reg_irq, 32'd0, resp_okay);

            // Frame 2 runs with the layer off
            shadow_cfg.scroll_x = 7'($urandom);
            shadow_cfg.scroll_y = 7'($urandom);
            shadow_cfg.enable = (f != 2);
            shadow_cfg.pal_bank = 2'($urandom);
            shadow_cfg.bg_colour = 4'($urandom);
            shadow_irq_en = (f != 1);
            write_checked(reg_scroll_x, {25'd0, shadow_cfg.scroll_x}, resp_okay);
            write_checked(reg_scroll_y, {25'd0, shadow_cfg.scroll_y}, resp_okay);
            write_checked(reg_ctrl, ctrl_word(shadow_cfg, shadow_irq_en), resp_okay);
            read_back_regs();
            // Line 0 is rendered during the last vblank line
            if (video.lvbl || video.vdump == 7'(v_total - 1)) begin
                report_error("Register updates did not finish inside vblank");
            end
            model_ok = 1'b1;

            if (f == 0) begin
                // Unmapped space checked while the frame is on screen
                for (int k = 0; k < 8; k++) begin
                    bad_addr = 12'h410 + 12'($urandom_range(763, 0) * 4);
                    write_checked(bad_addr, $urandom, resp_slverr);
                    read_checked(bad_addr, 32'd0, resp_slverr);
                    // Map word that a partial address decode would hit
                    idx = bad_addr[9:2];
                    read_checked({2'b00, idx, 2'b00}, {21'd0, shadow_map[idx]}, resp_okay);
                end
                read_back_regs();
            end
        end

        wait_vblank();
        check_irq(irq_n, !shadow_irq_en);
        repeat (2) @(negedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
